/* hdl/conv_pkg.sv */
package conv_pkg;

	//////////////////////////////////////////////////
	// Layer sizes
	localparam int img_pixels   = 16;
	localparam int ch_in        = 4;
	localparam int ch_out       = 4;
	localparam int weight_words = ch_out * ch_in;
	localparam int pixel_words  = ch_in * img_pixels;
	localparam int frame_words  = weight_words + pixel_words;

	//////////////////////////////////////////////////
	// Memory map
	// Weight (o, c) at o*ch_in + c
	localparam int weight_base = 0;
	// Pixel p, channel c at pixel_base + p*ch_in + c
	localparam int pixel_base  = weight_words;

	//////////////////////////////////////////////////
	// Vector types
	typedef logic signed [15:0] data_t;
	typedef logic signed [31:0] acc_t;
	typedef logic        [6:0]  addr_t;

	// Replay buffer FSM
	typedef enum logic [1:0] {
		rs_idle,
		rs_load,
		rs_replay,
		rs_done
	} replay_state_t;

	// Arbiter FSM
	typedef enum logic [1:0] {
		arb_idle,
		arb_access,
		arb_ack
	} arb_state_t;

endpackage

/* hdl/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;
	import conv_pkg::*;

	// Request side, held stable while req is high
	logic  req;
	logic  we;
	addr_t addr;
	data_t wdata;

	// Response side, rdata valid while ack is high
	logic  ack;
	data_t rdata;

	modport requester (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output ack, rdata
	);

endinterface

/* hdl/frame_sram.sv */
`timescale 1ns/1ps

module frame_sram (
	input  logic            clk,
	input  logic            en,
	input  logic            we,
	input  conv_pkg::addr_t addr,
	input  conv_pkg::data_t wdata,
	output conv_pkg::data_t rdata
);
	import conv_pkg::*;

	// Weights first, then the feature map
	data_t mem [frame_words];

	// Read-first port, output register holds between accesses
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr];
		end
	end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic            clk,
	input  logic            reset,
	mem_req_if.arbiter      port_a,
	mem_req_if.arbiter      port_b,
	output logic            ram_en,
	output logic            ram_we,
	output conv_pkg::addr_t ram_addr,
	output conv_pkg::data_t ram_wdata,
	input  conv_pkg::data_t ram_rdata
);
	import conv_pkg::*;

	arb_state_t state;
	logic       prio_b;
	logic       grant_b;
	logic       pick_b;
	logic       grant_new;
	logic       lat_we;
	addr_t      lat_addr;
	data_t      lat_wdata;

	//////////////////////////////////////////////////
	// Grant decision

	// Port b wins when alone or when it holds priority
	assign pick_b    = port_b.req && (!port_a.req || prio_b);
	assign grant_new = (state == arb_idle) && (port_a.req || port_b.req);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= arb_idle;
			prio_b  <= 1'b0;
			grant_b <= 1'b0;
		end else begin
			case (state)
				arb_idle: begin
					if (grant_new) begin
						grant_b <= pick_b;
						// Other side goes first next time
						prio_b  <= !pick_b;
						state   <= arb_access;
					end
				end
				arb_access: begin
					state <= arb_ack;
				end
				arb_ack: begin
					if (grant_b ? !port_b.req : !port_a.req) begin
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	// Latched request of the granted port
	always_ff @(posedge clk) begin
		if (grant_new) begin
			lat_we    <= pick_b ? port_b.we    : port_a.we;
			lat_addr  <= pick_b ? port_b.addr  : port_a.addr;
			lat_wdata <= pick_b ? port_b.wdata : port_a.wdata;
		end
	end

	//////////////////////////////////////////////////
	// RAM side

	assign ram_en    = (state == arb_access);
	assign ram_we    = lat_we;
	assign ram_addr  = lat_addr;
	assign ram_wdata = lat_wdata;

	// RAM output register keeps the read word during ack
	assign port_a.ack   = (state == arb_ack) && !grant_b;
	assign port_b.ack   = (state == arb_ack) && grant_b;
	assign port_a.rdata = ram_rdata;
	assign port_b.rdata = ram_rdata;

endmodule

/* hdl/feature_replay_buffer.sv */
`timescale 1ns/1ps

module feature_replay_buffer (
	input  logic            clk,
	input  logic            reset,
	input  logic            load_valid,
	input  conv_pkg::data_t load_data,
	output logic            load_ready,
	mem_req_if.requester    mem,
	output logic            pix_valid,
	output conv_pkg::data_t pix_data,
	input  logic            pix_ready,
	output logic            replay_go,
	output logic            busy
);
	import conv_pkg::*;

	replay_state_t                  state;
	addr_t                          wr_cnt;
	logic [$clog2(pixel_words)-1:0] rd_idx;
	logic [$clog2(ch_out)-1:0]      pass;
	logic                           mem_free;
	logic                           rd_issue;
	logic                           rd_done;
	logic                           pix_xfer;

	// No handshake in flight
	assign mem_free = !mem.req && !mem.ack;

	// One load word per completed four-phase write
	assign load_ready = load_valid && mem_free && (wr_cnt < frame_words) &&
		(state == rs_idle || state == rs_load);

	// Next pixel read only once the previous word has left
	assign rd_issue = (state == rs_replay) && mem_free && !pix_valid;
	assign rd_done  = mem.req && mem.ack && !mem.we;
	assign pix_xfer = pix_valid && pix_ready;

	//////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= rs_idle;
			mem.req   <= 1'b0;
			pix_valid <= 1'b0;
			replay_go <= 1'b0;
			busy      <= 1'b0;
			wr_cnt    <= '0;
			rd_idx    <= '0;
			pass      <= '0;
		end else begin
			if (mem.req && mem.ack) begin
				mem.req <= 1'b0;
			end
			if (rd_done) begin
				pix_valid <= 1'b1;
			end
			if (pix_xfer) begin
				pix_valid <= 1'b0;
			end

			case (state)
				rs_idle, rs_load: begin
					if (load_ready) begin
						mem.req <= 1'b1;
						wr_cnt  <= wr_cnt + 1'b1;
						busy    <= 1'b1;
						state   <= rs_load;
					end else if (state == rs_load && wr_cnt == frame_words && mem_free) begin
						replay_go <= 1'b1;
						state     <= rs_replay;
					end
				end
				rs_replay: begin
					if (rd_issue) begin
						mem.req <= 1'b1;
					end
					// Pass counter steps once per output channel
					if (pix_xfer) begin
						if (rd_idx == pixel_words - 1) begin
							rd_idx <= '0;
							if (pass == ch_out - 1) begin
								pass  <= '0;
								state <= rs_done;
							end else begin
								pass <= pass + 1'b1;
							end
						end else begin
							rd_idx <= rd_idx + 1'b1;
						end
					end
				end
				rs_done: begin
					replay_go <= 1'b0;
					busy      <= 1'b0;
					wr_cnt    <= '0;
					state     <= rs_idle;
				end
				default: begin
					state <= rs_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Request and pixel payload

	always_ff @(posedge clk) begin
		if (load_ready) begin
			mem.we    <= 1'b1;
			mem.addr  <= wr_cnt;
			mem.wdata <= load_data;
		end else if (rd_issue) begin
			mem.we   <= 1'b0;
			mem.addr <= addr_t'(pixel_base + int'(rd_idx));
		end
		if (rd_done) begin
			pix_data <= mem.rdata;
		end
	end

endmodule

/* hdl/weight_fetch.sv */
`timescale 1ns/1ps

module weight_fetch (
	input  logic            clk,
	input  logic            reset,
	input  logic            replay_go,
	mem_req_if.requester    mem,
	output logic            wgt_valid,
	output conv_pkg::data_t wgt_data,
	input  logic            wgt_ready
);
	import conv_pkg::*;

	logic [$clog2(ch_in)-1:0]      c_idx;
	logic [$clog2(img_pixels)-1:0] p_idx;
	logic [$clog2(ch_out)-1:0]     o_idx;
	logic                          finished;
	logic                          rd_issue;
	logic                          wgt_xfer;

	// Read only
	assign mem.we    = 1'b0;
	assign mem.wdata = '0;

	assign rd_issue = replay_go && !finished && !mem.req && !mem.ack && !wgt_valid;
	assign wgt_xfer = wgt_valid && wgt_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem.req   <= 1'b0;
			wgt_valid <= 1'b0;
			finished  <= 1'b0;
			c_idx     <= '0;
			p_idx     <= '0;
			o_idx     <= '0;
		end else begin
			if (rd_issue) begin
				mem.req <= 1'b1;
			end
			if (mem.req && mem.ack) begin
				mem.req   <= 1'b0;
				wgt_valid <= 1'b1;
			end
			// Channel c inner, same weight row once per pixel, then next o
			if (wgt_xfer) begin
				wgt_valid <= 1'b0;
				c_idx     <= c_idx + 1'b1;
				if (c_idx == ch_in - 1) begin
					p_idx <= p_idx + 1'b1;
					if (p_idx == img_pixels - 1) begin
						o_idx <= o_idx + 1'b1;
						if (o_idx == ch_out - 1) begin
							finished <= 1'b1;
						end
					end
				end
			end
			// Rearm for the next frame
			if (finished && !replay_go) begin
				finished <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_issue) begin
			mem.addr <= addr_t'(weight_base + int'(o_idx) * ch_in + int'(c_idx));
		end
		if (mem.req && mem.ack) begin
			wgt_data <= mem.rdata;
		end
	end

endmodule

/* hdl/pointwise_mac.sv */
`timescale 1ns/1ps

module pointwise_mac (
	input  logic            clk,
	input  logic            reset,
	input  logic            pix_valid,
	input  conv_pkg::data_t pix_data,
	output logic            pix_ready,
	input  logic            wgt_valid,
	input  conv_pkg::data_t wgt_data,
	output logic            wgt_ready,
	output logic            out_valid,
	output conv_pkg::acc_t  out_data,
	input  logic            out_ready
);
	import conv_pkg::*;

	logic [$clog2(ch_in)-1:0] cnt;
	acc_t                     acc;
	acc_t                     prod;
	acc_t                     sum;
	logic                     last;
	logic                     room;
	logic                     take;

	// Full 32-bit signed product, sums wrap
	assign prod = acc_t'(pix_data) * acc_t'(wgt_data);
	assign sum  = acc + prod;
	assign last = (cnt == ch_in - 1);

	// Stall only if this pair would finish a sum while a result is still held
	assign room      = !last || !out_valid || out_ready;
	assign pix_ready = wgt_valid && room;
	assign wgt_ready = pix_valid && room;
	assign take      = pix_valid && wgt_valid && room;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt       <= '0;
			acc       <= '0;
			out_valid <= 1'b0;
		end else begin
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (take) begin
				if (last) begin
					cnt       <= '0;
					acc       <= '0;
					out_valid <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
					acc <= sum;
				end
			end
		end
	end

	// Result register
	always_ff @(posedge clk) begin
		if (take && last) begin
			out_data <= sum;
		end
	end

endmodule

/* hdl/conv1x1_top.sv */
`timescale 1ns/1ps

module conv1x1_top (
	input  logic            clk,
	input  logic            reset,
	input  logic            load_valid,
	input  conv_pkg::data_t load_data,
	output logic            load_ready,
	output logic            out_valid,
	output conv_pkg::acc_t  out_data,
	input  logic            out_ready,
	output logic            busy
);
	import conv_pkg::*;

	logic  ram_en;
	logic  ram_we;
	addr_t ram_addr;
	data_t ram_wdata;
	data_t ram_rdata;
	logic  pix_valid;
	data_t pix_data;
	logic  pix_ready;
	logic  wgt_valid;
	data_t wgt_data;
	logic  wgt_ready;
	logic  replay_go;

	//////////////////////////////////////////////////
	// Shared frame memory

	mem_req_if buf_mem ();
	mem_req_if wgt_mem ();

	frame_sram i_sram (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.addr (ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	mem_arbiter i_arbiter (
		.clk      (clk),
		.reset    (reset),
		.port_a   (buf_mem),
		.port_b   (wgt_mem),
		.ram_en   (ram_en),
		.ram_we   (ram_we),
		.ram_addr (ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	//////////////////////////////////////////////////
	// Operand fetch and MAC

	feature_replay_buffer i_replay (
		.clk       (clk),
		.reset     (reset),
		.load_valid(load_valid),
		.load_data (load_data),
		.load_ready(load_ready),
		.mem       (buf_mem),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.pix_ready (pix_ready),
		.replay_go (replay_go),
		.busy      (busy)
	);

	weight_fetch i_weights (
		.clk      (clk),
		.reset    (reset),
		.replay_go(replay_go),
		.mem      (wgt_mem),
		.wgt_valid(wgt_valid),
		.wgt_data (wgt_data),
		.wgt_ready(wgt_ready)
	);

	pointwise_mac i_mac (
		.clk      (clk),
		.reset    (reset),
		.pix_valid(pix_valid),
		.pix_data (pix_data),
		.pix_ready(pix_ready),
		.wgt_valid(wgt_valid),
		.wgt_data (wgt_data),
		.wgt_ready(wgt_ready),
		.out_valid(out_valid),
		.out_data (out_data),
		.out_ready(out_ready)
	);

endmodule

/* bench/conv_checker.sv */
`timescale 1ns/1ps

module conv_checker (
	input  logic            clk,
	input  logic            reset,
	input  logic            load_valid,
	input  conv_pkg::data_t load_data,
	input  logic            load_ready,
	input  logic            out_valid,
	input  conv_pkg::acc_t  out_data,
	input  logic            out_ready,
	output int              result_count,
	output int              error_count
);
	import conv_pkg::*;

	localparam int results_per_frame = ch_out * img_pixels;

	data_t frame [frame_words];
	acc_t  expected [$];
	int    load_idx;
	logic  held;
	acc_t  held_data;

	//////////////////////////////////////////////////
	// Reference model

	function automatic acc_t model_result(input int o, input int p);
		longint total;
		total = 0;
		for (int c = 0; c < ch_in; c++) begin
			total += longint'(frame[weight_base + o * ch_in + c]) *
				longint'(frame[pixel_base + p * ch_in + c]);
		end
		// 32-bit result, wraps like the hardware sum
		return acc_t'(total);
	endfunction

	//////////////////////////////////////////////////
	// Port monitor, sampled mid-cycle where all signals are settled

	always @(negedge clk) begin
		int idx;
		acc_t exp_val;
		if (reset) begin
			load_idx     = 0;
			held         = 1'b0;
			result_count = 0;
			error_count  = 0;
			expected.delete();
		end else begin
			// Frame capture, results queued once the last word is in
			if (load_valid && load_ready) begin
				frame[load_idx] = load_data;
				load_idx++;
				if (load_idx == frame_words) begin
					load_idx = 0;
					for (int o = 0; o < ch_out; o++) begin
						for (int p = 0; p < img_pixels; p++) begin
							expected.push_back(model_result(o, p));
						end
					end
				end
			end

			// A held result must not change
			if (held) begin
				if (!out_valid) begin
					$display("out_valid dropped while out_ready was low");
					error_count++;
				end else if (out_data !== held_data) begin
					$display("Mismatch out_data while held: expected %h actual %h",
						held_data, out_data);
					error_count++;
				end
			end
			held      = out_valid && !out_ready;
			held_data = out_data;

			// Result comparison, channel outer and pixel inner
			if (out_valid && out_ready) begin
				idx = result_count % results_per_frame;
				if (expected.size() == 0) begin
					$display("Result appeared with no expected value pending");
					error_count++;
				end else begin
					exp_val = expected.pop_front();
					if (out_data !== exp_val) begin
						$display("Mismatch out_data: o=%0d p=%0d expected %h actual %h",
							idx / img_pixels, idx % img_pixels, exp_val, out_data);
						error_count++;
					end
				end
				result_count++;
			end
		end
	end

endmodule

/* bench/tb_conv1x1.sv */
`timescale 1ns/1ps

module tb_conv1x1;
	import conv_pkg::*;

	localparam int results_per_frame = ch_out * img_pixels;
	localparam int word_timeout      = 100;
	localparam int result_timeout    = 2000;

	logic  clk;
	logic  reset;
	logic  load_valid;
	data_t load_data;
	logic  load_ready;
	logic  out_valid;
	acc_t  out_data;
	logic  out_ready = 1'b0;
	logic  busy;

	int    seed;
	logic  random_ready;
	logic  timed_out;
	int    result_count;
	int    error_count;
	int    bench_errors;
	int    tests_run;
	int    tests_failed;

	conv1x1_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.load_valid(load_valid),
		.load_data (load_data),
		.load_ready(load_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready),
		.busy      (busy)
	);

	conv_checker i_checker (
		.clk         (clk),
		.reset       (reset),
		.load_valid  (load_valid),
		.load_data   (load_data),
		.load_ready  (load_ready),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_ready   (out_ready),
		.result_count(result_count),
		.error_count (error_count)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Random or steady result back-pressure, drawn on the edge
	always @(posedge clk) begin
		int   rnd;
		logic next_ready;
		rnd        = $random(seed);
		next_ready = random_ready ? rnd[0] : 1'b1;
		#2;
		out_ready = next_ready;
	end

	//////////////////////////////////////////////////
	// Stimulus and wait tasks

	task automatic load_frame(input int kind, input logic gaps);
		data_t word;
		int    rnd;
		int    waited;
		logic  hit;
		for (int i = 0; i < frame_words && !timed_out; i++) begin
			rnd = $random(seed);
			case (kind)
				0: word = rnd[15:0];
				1: word = 16'sh8000;
				default: word = ((i + i / ch_in) % 2 == 0) ? 16'sh7fff : 16'sh8000;
			endcase
			if (gaps) begin
				load_valid = 1'b0;
				repeat (rnd[17:16]) begin
					@(posedge clk);
					#2;
				end
			end
			load_valid = 1'b1;
			load_data  = word;
			hit        = 1'b0;
			waited     = 0;
			while (!hit && !timed_out) begin
				@(negedge clk);
				hit = load_ready;
				@(posedge clk);
				#2;
				waited++;
				if (!hit && waited >= word_timeout) begin
					$display("Timeout waiting for load_ready on word %0d", i);
					timed_out = 1'b1;
				end
			end
		end
		load_valid = 1'b0;
	endtask

	task automatic wait_results(input int target);
		int idle;
		int last;
		idle = 0;
		last = result_count;
		while (result_count < target && !timed_out) begin
			@(posedge clk);
			#2;
			if (result_count != last) begin
				last = result_count;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle >= result_timeout) begin
				$display("Timeout waiting for result %0d, got %0d", target, result_count);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (busy && !timed_out) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited >= result_timeout) begin
				$display("Timeout waiting for busy to fall");
				timed_out = 1'b1;
			end
		end
	endtask

	// Nothing may move while no frame is in flight
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (out_valid) begin
				$display("out_valid high with no result due, cycle %0d", i);
				bench_errors++;
			end
			if (load_ready) begin
				$display("load_ready high with no load word offered, cycle %0d", i);
				bench_errors++;
			end
			if (busy) begin
				$display("busy high with no frame in progress, cycle %0d", i);
				bench_errors++;
			end
			@(posedge clk);
			#2;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		int errs;
		errs = error_count + bench_errors - start_errors;
		tests_run++;
		if (errs > 0 || timed_out) begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, errs);
		end else begin
			$display("Test %s passed", name);
		end
	endtask

	task automatic run_frame(input string name, input int kind, input logic gaps,
		input logic rand_ready);
		int start_errors;
		int target;
		start_errors = error_count + bench_errors;
		target       = result_count + results_per_frame;
		random_ready = rand_ready;
		load_frame(kind, gaps);
		wait_results(target);
		random_ready = 1'b0;
		wait_idle();
		if (!timed_out) begin
			check_quiet(20);
			if (result_count != target) begin
				$display("Mismatch result_count: expected %h actual %h", target, result_count);
				bench_errors++;
			end
		end
		finish_test(name, start_errors);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		int start_errors;
		seed         = 7;
		reset        = 1'b1;
		load_valid   = 1'b0;
		load_data    = '0;
		random_ready = 1'b0;
		timed_out    = 1'b0;
		bench_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		start_errors = error_count + bench_errors;
		check_quiet(10);
		finish_test("reset_quiet", start_errors);

		if (!timed_out) run_frame("random_frame", 0, 1'b0, 1'b0);
		if (!timed_out) run_frame("random_backpressure", 0, 1'b0, 1'b1);
		if (!timed_out) run_frame("all_min_frame", 1, 1'b0, 1'b0);
		if (!timed_out) run_frame("alternating_extremes", 2, 1'b0, 1'b0);
		if (!timed_out) run_frame("paced_load", 0, 1'b1, 1'b0);

		$display("Tests run %0d, failed %0d, checker errors %0d, bench errors %0d",
			tests_run, tests_failed, error_count, bench_errors);
		if (tests_failed == 0 && !timed_out && error_count == 0 && bench_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* conv1x1_top.f */
hdl/conv_pkg.sv
hdl/mem_req_if.sv
hdl/frame_sram.sv
hdl/mem_arbiter.sv
hdl/feature_replay_buffer.sv
hdl/weight_fetch.sv
hdl/pointwise_mac.sv
hdl/conv1x1_top.sv
bench/conv_checker.sv
bench/tb_conv1x1.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv1x1
FILELIST  ?= conv1x1_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
